/* dma_fir_tests.txt */
// first word: number of records
// each record: sdram base, taps 0 to 5 / taps 6 to 10, busy percent
00000006
// small positive taps, controller never busy
00000100 00000001 00000002 00000003 00000004 00000005 00000006
00000007 00000008 00000009 0000000A 0000000B 00
// mixed signs and extreme values, light busy
00000237 FFFFFFFF 00000002 FFFFFFFD 00000004 00000000 00000000
7FFFFFFF 80000000 00000010 00000000 00000001 14
// base near the top, address wraps
007FFFE0 00001234 FFFFEDCC 00000100 00000003 FFFFFF00 0000000F
00000020 FFFFFFF0 00000040 00000001 00000007 32
// large taps, heavy busy
000000A5 12345678 9ABCDEF0 0F0F0F0F F0F0F0F0 00000001 DEADBEEF
CAFEF00D 00000000 55555555 AAAAAAAA 13579BDF 5A
// all taps minus one
003FFF00 FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF
FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF 46
// delayed copy of the input
00000001 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000001 0A

/* all.f */
dma_fir_pkg.sv
sdram_prefetch.sv
fir_core.sv
dma_sequencer.sv
dma_fir_top.sv
sdram_model.sv
dma_fir_props.sv
tb_dma_fir.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
verilator --binary --timing --assert --top-module tb_dma_fir -f all.f \
    && ./obj_dir/Vtb_dma_fir | tee /dev/stderr | grep "ALL CHECKS PASSED" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tb_dma_fir.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_dma_fir;

    logic                                   wb_clk_i;
    logic                                   wb_rst_i;
    logic                                   wbs_stb_i;
    logic                                   wbs_cyc_i;
    logic                                   wbs_we_i;
    logic [31:0]                            wbs_adr_i;
    logic [dma_fir_pkg::DATA_W-1:0]         wbs_dat_i;
    logic                                   wbs_ack_o;
    logic [dma_fir_pkg::DATA_W-1:0]         wbs_dat_o;
    logic [dma_fir_pkg::SDRAM_ADDR_W-1:0]   sdram_addr;
    logic                                   sdram_req;
    logic                                   sdram_busy;
    logic [dma_fir_pkg::DATA_W-1:0]         sdram_rdata;
    logic                                   sdram_rvalid;
    logic [7:0]                             busy_pct;

    logic [31:0] test_words [256];  // record count, then 13 words per record
    logic [dma_fir_pkg::DATA_W-1:0] taps [dma_fir_pkg::NUM_TAPS];
    logic [dma_fir_pkg::DATA_W-1:0] expected [dma_fir_pkg::SAMPLE_COUNT];
    int mismatches;
    int timeouts;

    dma_fir_top u_dma_fir_top (
        .wb_clk_i       (wb_clk_i),
        .wb_rst_i       (wb_rst_i),
        .wbs_stb_i      (wbs_stb_i),
        .wbs_cyc_i      (wbs_cyc_i),
        .wbs_we_i       (wbs_we_i),
        .wbs_adr_i      (wbs_adr_i),
        .wbs_dat_i      (wbs_dat_i),
        .wbs_ack_o      (wbs_ack_o),
        .wbs_dat_o      (wbs_dat_o),
        .sdram_addr_o   (sdram_addr),
        .sdram_req_o    (sdram_req),
        .sdram_busy_i   (sdram_busy),
        .sdram_rdata_i  (sdram_rdata),
        .sdram_rvalid_i (sdram_rvalid)
    );

    sdram_model u_sdram (
        .wb_clk_i       (wb_clk_i),
        .wb_rst_i       (wb_rst_i),
        .busy_pct_i     (busy_pct),
        .sdram_addr_i   (sdram_addr),
        .sdram_req_i    (sdram_req),
        .sdram_busy_o   (sdram_busy),
        .sdram_rdata_o  (sdram_rdata),
        .sdram_rvalid_o (sdram_rvalid)
    );

    always #2 wb_clk_i = ~wb_clk_i;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            mismatches++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic apply_reset(input logic [7:0] pct);
        @(posedge wb_clk_i);
        wb_rst_i <= 1'b1;
        busy_pct <= pct;
        repeat (5) @(posedge wb_clk_i);
        wb_rst_i <= 1'b0;
        @(negedge wb_clk_i);
    endtask

    // one single-cycle strobe, then wait for the ack
    task automatic bus_access(input logic write, input logic [7:0] offset,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        @(posedge wb_clk_i);
        wbs_stb_i <= 1'b1;
        wbs_cyc_i <= 1'b1;
        wbs_we_i  <= write;
        wbs_adr_i <= {24'h0, offset};
        wbs_dat_i <= wdata;
        @(posedge wb_clk_i);
        wbs_stb_i <= 1'b0;
        wbs_cyc_i <= 1'b0;
        wbs_we_i  <= 1'b0;
        waited = 1;
        @(negedge wb_clk_i);
        while (!wbs_ack_o && waited < 8) begin
            @(negedge wb_clk_i);
            waited++;
        end
        assert (wbs_ack_o) else begin
            timeouts++;
            $display("timeout: no ack for the access at offset %h", offset);
        end
        if (wbs_ack_o) begin
            check_value("ack delay in cycles", 32'(waited), 32'd1);
        end
        rdata = wbs_dat_o;
    endtask

    // y[n] sums the signed products taps[k] * x[n-k] modulo 2^32
    task automatic compute_expected(input logic [dma_fir_pkg::SDRAM_ADDR_W-1:0] base);
        logic [31:0] x [dma_fir_pkg::SAMPLE_COUNT];
        logic [dma_fir_pkg::SDRAM_ADDR_W-1:0] addr;
        longint prod;
        for (int i = 0; i < dma_fir_pkg::SAMPLE_COUNT; i++) begin
            addr = base + 23'(i);
            x[i] = u_sdram.mem[addr[7:0]];
        end
        for (int n = 0; n < dma_fir_pkg::SAMPLE_COUNT; n++) begin
            expected[n] = '0;
            for (int k = 0; k < dma_fir_pkg::NUM_TAPS && k <= n; k++) begin
                prod = longint'(signed'(taps[k])) * longint'(signed'(x[n-k]));
                expected[n] = expected[n] + prod[31:0];
            end
        end
    endtask

    initial begin
        logic [31:0] rdata;
        logic [dma_fir_pkg::SDRAM_ADDR_W-1:0] base;
        logic [dma_fir_pkg::SDRAM_ADDR_W-1:0] addr_exp;
        int nrec;
        int idx;
        int polls;
        int prop_fails;
        wb_clk_i   = 1'b0;
        wb_rst_i   = 1'b1;
        wbs_stb_i  = 1'b0;
        wbs_cyc_i  = 1'b0;
        wbs_we_i   = 1'b0;
        wbs_adr_i  = '0;
        wbs_dat_i  = '0;
        busy_pct   = 8'd0;
        mismatches = 0;
        timeouts   = 0;
        void'($urandom(52038));
        $readmemh("dma_fir_tests.txt", test_words);
        u_sdram.fill_memory();
        nrec = int'(test_words[0]);

        for (int r = 0; r < nrec; r++) begin
            idx  = 1 + r * 13;
            base = test_words[idx][dma_fir_pkg::SDRAM_ADDR_W-1:0];
            for (int k = 0; k < dma_fir_pkg::NUM_TAPS; k++)
                taps[k] = test_words[idx+1+k];
            apply_reset(test_words[idx+12][7:0]);
            check_value("ack after reset", 32'(wbs_ack_o), 32'd0);
            check_value("sdram request after reset", 32'(sdram_req), 32'd0);

            bus_access(1'b0, dma_fir_pkg::REG_CTRL, '0, rdata);
            check_value("idle status", rdata, 32'd1 << dma_fir_pkg::CTRL_IDLE_BIT);

            for (int k = 0; k < dma_fir_pkg::NUM_TAPS; k++)
                bus_access(1'b1, dma_fir_pkg::REG_TAP_BASE + 8'(4 * k), taps[k], rdata);
            for (int k = 0; k < dma_fir_pkg::NUM_TAPS; k++) begin
                bus_access(1'b0, dma_fir_pkg::REG_TAP_BASE + 8'(4 * k), '0, rdata);
                check_value($sformatf("tap %0d readback", k), rdata, taps[k]);
            end

            bus_access(1'b1, dma_fir_pkg::REG_BASE_ADDR, {9'h0, base}, rdata);
            bus_access(1'b1, dma_fir_pkg::REG_CTRL, 32'd1 << dma_fir_pkg::CTRL_START_BIT, rdata);
            bus_access(1'b0, dma_fir_pkg::REG_CTRL, '0, rdata);
            check_value("status read during run", rdata, 32'd0);

            polls = 0;
            do begin
                bus_access(1'b0, dma_fir_pkg::REG_CTRL, '0, rdata);
                polls++;
            end while (!rdata[dma_fir_pkg::CTRL_DONE_BIT] && polls < 5000);
            assert (rdata[dma_fir_pkg::CTRL_DONE_BIT]) else begin
                timeouts++;
                $display("timeout: record %0d never reported done", r);
            end

            compute_expected(base);
            for (int i = 0; i < dma_fir_pkg::NUM_TAPS; i++) begin
                bus_access(1'b0, dma_fir_pkg::REG_RESULT_BASE + 8'(4 * i), '0, rdata);
                check_value($sformatf("record %0d result %0d", r, i), rdata,
                            expected[dma_fir_pkg::SAMPLE_COUNT - dma_fir_pkg::NUM_TAPS + i]);
            end

            check_value("sdram request count", 32'(u_sdram.req_log.size()),
                        32'(dma_fir_pkg::SAMPLE_COUNT));
            for (int i = 0; i < u_sdram.req_log.size() && i < dma_fir_pkg::SAMPLE_COUNT; i++) begin
                addr_exp = base + 23'(i);
                check_value($sformatf("sdram request %0d address", i),
                            {9'h0, u_sdram.req_log[i]}, {9'h0, addr_exp});
            end
        end

        prop_fails = u_dma_fir_top.u_props.fail_total;
        $display("error counts: mismatch %0d, timeout %0d, assertion %0d",
                 mismatches, timeouts, prop_fails);
        if (mismatches == 0 && timeouts == 0 && prop_fails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dma_fir_props.sv */
`timescale 1ns/1ns
`default_nettype none

module dma_fir_props (
    input wire wb_clk_i,
    input wire wb_rst_i,
    input wire wbs_stb_i,
    input wire wbs_cyc_i,
    input wire wbs_ack_i,
    input wire sdram_req_i,
    input wire sdram_busy_i
);

    int ack_fails = 0;
    int req_fails = 0;
    int stb_fails = 0;
    int fail_total;

    assign fail_total = ack_fails + req_fails + stb_fails;

    ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        wbs_ack_i |=> !wbs_ack_i)
    else begin
        $error("host ack was high in two consecutive cycles");
        ack_fails++;
    end

    // a busy controller must see the request again
    req_hold: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        sdram_req_i && sdram_busy_i |=> sdram_req_i)
    else begin
        $error("sdram request dropped while the controller was busy");
        req_fails++;
    end

    ack_after_stb: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        wbs_ack_i |-> $past(wbs_stb_i && wbs_cyc_i))
    else begin
        $error("host ack without a strobe in the cycle before");
        stb_fails++;
    end

endmodule

bind dma_fir_top dma_fir_props u_props (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .wbs_stb_i    (wbs_stb_i),
    .wbs_cyc_i    (wbs_cyc_i),
    .wbs_ack_i    (wbs_ack_o),
    .sdram_req_i  (sdram_req_o),
    .sdram_busy_i (sdram_busy_i)
);

`default_nettype wire

/* sdram_model.sv */
`timescale 1ns/1ns
`default_nettype none

module sdram_model (
    input  wire                                    wb_clk_i,
    input  wire                                    wb_rst_i,
    input  wire  [7:0]                             busy_pct_i,
    input  wire  [dma_fir_pkg::SDRAM_ADDR_W-1:0]   sdram_addr_i,
    input  wire                                    sdram_req_i,
    output logic                                   sdram_busy_o,
    output logic [dma_fir_pkg::DATA_W-1:0]         sdram_rdata_o,
    output logic                                   sdram_rvalid_o
);

    logic [dma_fir_pkg::DATA_W-1:0] mem [256];  // indexed by the low address byte
    logic [dma_fir_pkg::SDRAM_ADDR_W-1:0] req_log [$];
    logic [dma_fir_pkg::SDRAM_ADDR_W-1:0] rd_addr;
    logic pending;
    logic [2:0] lat_cnt;

    task automatic fill_memory();
        for (int i = 0; i < 256; i++)
            mem[i] = $urandom;
    endtask

    always @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            sdram_busy_o   <= 1'b0;
            sdram_rvalid_o <= 1'b0;
            sdram_rdata_o  <= '0;
            pending        <= 1'b0;
            lat_cnt        <= 3'd0;
            req_log.delete();
        end else begin
            sdram_rvalid_o <= 1'b0;
            sdram_busy_o   <= ($urandom % 32'd100) < 32'(busy_pct_i);
            if (sdram_req_i && !sdram_busy_o && !pending) begin
                req_log.push_back(sdram_addr_i);  // accepted this cycle
                rd_addr <= sdram_addr_i;
                lat_cnt <= 3'($urandom % 32'd4);
                pending <= 1'b1;
            end else if (pending) begin
                if (lat_cnt == 3'd0) begin
                    sdram_rvalid_o <= 1'b1;
                    sdram_rdata_o  <= mem[rd_addr[7:0]];
                    pending        <= 1'b0;
                end else begin
                    lat_cnt <= lat_cnt - 3'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* dma_fir_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dma_fir_top (
    input  wire                                    wb_clk_i,
    input  wire                                    wb_rst_i,
    input  wire                                    wbs_stb_i,
    input  wire                                    wbs_cyc_i,
    input  wire                                    wbs_we_i,
    input  wire  [31:0]                            wbs_adr_i,
    input  wire  [dma_fir_pkg::DATA_W-1:0]         wbs_dat_i,
    output logic                                   wbs_ack_o,
    output logic [dma_fir_pkg::DATA_W-1:0]         wbs_dat_o,
    output logic [dma_fir_pkg::SDRAM_ADDR_W-1:0]   sdram_addr_o,
    output logic                                   sdram_req_o,
    input  wire                                    sdram_busy_i,
    input  wire  [dma_fir_pkg::DATA_W-1:0]         sdram_rdata_i,
    input  wire                                    sdram_rvalid_i
);

    logic                                   ack_next;
    logic [dma_fir_pkg::DATA_W-1:0]         dat_next;
    logic                                   base_load;
    logic [dma_fir_pkg::SDRAM_ADDR_W-1:0]   base_addr;
    logic [dma_fir_pkg::DATA_W-1:0]         sample;
    logic                                   sample_valid;
    logic                                   sample_take;
    logic                                   fir_stb;
    logic                                   fir_we;
    logic [dma_fir_pkg::REG_ADDR_W-1:0]     fir_adr;
    logic [dma_fir_pkg::DATA_W-1:0]         fir_wdat;
    logic                                   fir_ack;
    logic [dma_fir_pkg::DATA_W-1:0]         fir_rdat;

    sdram_prefetch u_prefetch (
        .wb_clk_i       (wb_clk_i),
        .wb_rst_i       (wb_rst_i),
        .base_load_i    (base_load),
        .base_addr_i    (base_addr),
        .sample_take_i  (sample_take),
        .sample_o       (sample),
        .sample_valid_o (sample_valid),
        .sdram_addr_o   (sdram_addr_o),
        .sdram_req_o    (sdram_req_o),
        .sdram_busy_i   (sdram_busy_i),
        .sdram_rdata_i  (sdram_rdata_i),
        .sdram_rvalid_i (sdram_rvalid_i)
    );

    dma_sequencer u_sequencer (
        .wb_clk_i       (wb_clk_i),
        .wb_rst_i       (wb_rst_i),
        .wbs_stb_i      (wbs_stb_i),
        .wbs_cyc_i      (wbs_cyc_i),
        .wbs_we_i       (wbs_we_i),
        .wbs_adr_i      (wbs_adr_i),
        .wbs_dat_i      (wbs_dat_i),
        .ack_next_o     (ack_next),
        .dat_next_o     (dat_next),
        .base_load_o    (base_load),
        .base_addr_o    (base_addr),
        .sample_i       (sample),
        .sample_valid_i (sample_valid),
        .sample_take_o  (sample_take),
        .fir_stb_o      (fir_stb),
        .fir_we_o       (fir_we),
        .fir_adr_o      (fir_adr),
        .fir_wdat_o     (fir_wdat),
        .fir_ack_i      (fir_ack),
        .fir_rdat_i     (fir_rdat)
    );

    fir_core u_fir (
        .wb_clk_i   (wb_clk_i),
        .wb_rst_i   (wb_rst_i),
        .fir_stb_i  (fir_stb),
        .fir_we_i   (fir_we),
        .fir_adr_i  (fir_adr),
        .fir_wdat_i (fir_wdat),
        .fir_ack_o  (fir_ack),
        .fir_rdat_o (fir_rdat)
    );

    // host response one cycle after the strobe
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i)
            wbs_ack_o <= 1'b0;
        else
            wbs_ack_o <= ack_next;
    end

    always_ff @(posedge wb_clk_i) begin
        wbs_dat_o <= dat_next;
    end

endmodule

`default_nettype wire

/* dma_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module dma_sequencer (
    input  wire                                    wb_clk_i,
    input  wire                                    wb_rst_i,
    input  wire                                    wbs_stb_i,
    input  wire                                    wbs_cyc_i,
    input  wire                                    wbs_we_i,
    input  wire  [31:0]                            wbs_adr_i,
    input  wire  [dma_fir_pkg::DATA_W-1:0]         wbs_dat_i,
    output logic                                   ack_next_o,
    output logic [dma_fir_pkg::DATA_W-1:0]         dat_next_o,
    output logic                                   base_load_o,
    output logic [dma_fir_pkg::SDRAM_ADDR_W-1:0]   base_addr_o,
    input  wire  [dma_fir_pkg::DATA_W-1:0]         sample_i,
    input  wire                                    sample_valid_i,
    output logic                                   sample_take_o,
    output logic                                   fir_stb_o,
    output logic                                   fir_we_o,
    output logic [dma_fir_pkg::REG_ADDR_W-1:0]     fir_adr_o,
    output logic [dma_fir_pkg::DATA_W-1:0]         fir_wdat_o,
    input  wire                                    fir_ack_i,
    input  wire  [dma_fir_pkg::DATA_W-1:0]         fir_rdat_i
);

    dma_fir_pkg::seq_state_e state;
    dma_fir_pkg::seq_state_e state_next;

    logic [dma_fir_pkg::DATA_W-1:0] results [dma_fir_pkg::NUM_TAPS];  // [0] is oldest

    logic host_req;
    logic host_wr;
    logic host_rd;
    logic [dma_fir_pkg::REG_ADDR_W-1:0] host_off;
    logic base_wr;
    logic start_wr;
    logic result_hit;
    logic running;
    logic result_shift;

    assign host_req   = wbs_stb_i & wbs_cyc_i;
    assign host_wr    = host_req & wbs_we_i;
    assign host_rd    = host_req & ~wbs_we_i;
    assign host_off   = wbs_adr_i[dma_fir_pkg::REG_ADDR_W-1:0];
    assign base_wr    = host_wr && (host_off == dma_fir_pkg::REG_BASE_ADDR);
    assign start_wr   = host_wr && (host_off == dma_fir_pkg::REG_CTRL)
                        && wbs_dat_i[dma_fir_pkg::CTRL_START_BIT];
    assign result_hit = dma_fir_pkg::word_in_window(host_off, dma_fir_pkg::REG_RESULT_BASE);

    assign running = (state == dma_fir_pkg::SEQ_POLL)
                     || (state == dma_fir_pkg::SEQ_STREAM_IN)
                     || (state == dma_fir_pkg::SEQ_STREAM_OUT);

    assign base_addr_o   = wbs_dat_i[dma_fir_pkg::SDRAM_ADDR_W-1:0];
    assign sample_take_o = (state == dma_fir_pkg::SEQ_STREAM_IN) && fir_ack_i;
    assign result_shift  = (state == dma_fir_pkg::SEQ_STREAM_OUT) && fir_ack_i;

    always_comb begin
        state_next  = state;
        base_load_o = 1'b0;
        // host passes through to the accelerator unless a state takes the bus
        fir_stb_o   = host_req;
        fir_we_o    = wbs_we_i;
        fir_adr_o   = host_off;
        fir_wdat_o  = wbs_dat_i;
        ack_next_o  = host_req & fir_ack_i;
        dat_next_o  = fir_rdat_i;

        case (state)
            dma_fir_pkg::SEQ_IDLE, dma_fir_pkg::SEQ_BASE_LOADED: begin
                if (base_wr) begin
                    fir_stb_o   = 1'b0;  // base register lives in the engine
                    ack_next_o  = 1'b1;
                    dat_next_o  = '0;
                    base_load_o = 1'b1;
                    state_next  = dma_fir_pkg::SEQ_BASE_LOADED;
                end else if (state == dma_fir_pkg::SEQ_BASE_LOADED && start_wr && fir_ack_i) begin
                    state_next = dma_fir_pkg::SEQ_POLL;
                end
            end
            dma_fir_pkg::SEQ_POLL: begin
                fir_stb_o  = 1'b1;
                fir_we_o   = 1'b0;
                fir_adr_o  = dma_fir_pkg::REG_CTRL;
                fir_wdat_o = '0;
                if (fir_ack_i) begin
                    if (fir_rdat_i[dma_fir_pkg::CTRL_X_READY_BIT] && sample_valid_i)
                        state_next = dma_fir_pkg::SEQ_STREAM_IN;
                    else if (fir_rdat_i[dma_fir_pkg::CTRL_Y_VALID_BIT])
                        state_next = dma_fir_pkg::SEQ_STREAM_OUT;
                    else if (fir_rdat_i[dma_fir_pkg::CTRL_DONE_BIT])
                        state_next = dma_fir_pkg::SEQ_DONE;
                end
            end
            dma_fir_pkg::SEQ_STREAM_IN: begin
                fir_stb_o  = 1'b1;
                fir_we_o   = 1'b1;
                fir_adr_o  = dma_fir_pkg::REG_X_IN;
                fir_wdat_o = sample_i;
                if (fir_ack_i)
                    state_next = dma_fir_pkg::SEQ_POLL;
            end
            dma_fir_pkg::SEQ_STREAM_OUT: begin
                fir_stb_o  = 1'b1;
                fir_we_o   = 1'b0;
                fir_adr_o  = dma_fir_pkg::REG_Y_OUT;
                fir_wdat_o = '0;
                if (fir_ack_i)
                    state_next = dma_fir_pkg::SEQ_POLL;
            end
            dma_fir_pkg::SEQ_DONE: begin
                if (host_rd && result_hit) begin
                    fir_stb_o  = 1'b0;
                    ack_next_o = 1'b1;
                    dat_next_o = results[dma_fir_pkg::word_index(host_off,
                                                                 dma_fir_pkg::REG_RESULT_BASE)];
                end
            end
            default: state_next = dma_fir_pkg::SEQ_IDLE;
        endcase

        // host gets zeros while the engine owns the accelerator
        if (running) begin
            ack_next_o = host_req;
            dat_next_o = '0;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i)
            state <= dma_fir_pkg::SEQ_IDLE;
        else
            state <= state_next;
    end

    // keeps the last NUM_TAPS outputs
    always_ff @(posedge wb_clk_i) begin
        if (result_shift) begin
            for (int i = 0; i < dma_fir_pkg::NUM_TAPS - 1; i++)
                results[i] <= results[i+1];
            results[dma_fir_pkg::NUM_TAPS-1] <= fir_rdat_i;
        end
    end

endmodule

`default_nettype wire

/* fir_core.sv */
`timescale 1ns/1ns
`default_nettype none

module fir_core (
    input  wire                                  wb_clk_i,
    input  wire                                  wb_rst_i,
    input  wire                                  fir_stb_i,
    input  wire                                  fir_we_i,
    input  wire  [dma_fir_pkg::REG_ADDR_W-1:0]   fir_adr_i,
    input  wire  [dma_fir_pkg::DATA_W-1:0]       fir_wdat_i,
    output logic                                 fir_ack_o,
    output logic [dma_fir_pkg::DATA_W-1:0]       fir_rdat_o
);

    logic [dma_fir_pkg::DATA_W-1:0] taps [dma_fir_pkg::NUM_TAPS];
    logic [dma_fir_pkg::DATA_W-1:0] delay [dma_fir_pkg::NUM_TAPS];  // [0] is newest
    logic [dma_fir_pkg::DATA_W-1:0] acc;
    logic signed [2*dma_fir_pkg::DATA_W-1:0] product;

    dma_fir_pkg::fir_state_e state;
    logic [dma_fir_pkg::TAP_IDX_W-1:0] mac_cnt;
    logic [dma_fir_pkg::COUNT_W-1:0] y_cnt;
    logic done;

    logic wr;
    logic tap_hit;
    logic [dma_fir_pkg::TAP_IDX_W-1:0] tap_idx;
    logic start_wr;
    logic x_wr;
    logic y_rd;
    logic mac_last;
    logic [dma_fir_pkg::DATA_W-1:0] status;

    assign wr       = fir_stb_i & fir_we_i;
    assign tap_hit  = dma_fir_pkg::word_in_window(fir_adr_i, dma_fir_pkg::REG_TAP_BASE);
    assign tap_idx  = dma_fir_pkg::word_index(fir_adr_i, dma_fir_pkg::REG_TAP_BASE);
    assign start_wr = wr && (fir_adr_i == dma_fir_pkg::REG_CTRL)
                      && fir_wdat_i[dma_fir_pkg::CTRL_START_BIT];
    assign x_wr     = wr && (fir_adr_i == dma_fir_pkg::REG_X_IN)
                      && (state == dma_fir_pkg::FIR_WAIT_X);
    assign y_rd     = fir_stb_i && !fir_we_i && (fir_adr_i == dma_fir_pkg::REG_Y_OUT)
                      && (state == dma_fir_pkg::FIR_Y_READY);
    assign mac_last = mac_cnt == dma_fir_pkg::TAP_IDX_W'(dma_fir_pkg::NUM_TAPS - 1);
    assign product  = $signed(taps[mac_cnt]) * $signed(delay[mac_cnt]);

    assign fir_ack_o = fir_stb_i;  // all registers answer at once

    always_comb begin
        status = '0;
        status[dma_fir_pkg::CTRL_DONE_BIT]    = done;
        status[dma_fir_pkg::CTRL_IDLE_BIT]    = state == dma_fir_pkg::FIR_IDLE;
        status[dma_fir_pkg::CTRL_X_READY_BIT] = state == dma_fir_pkg::FIR_WAIT_X;
        status[dma_fir_pkg::CTRL_Y_VALID_BIT] = state == dma_fir_pkg::FIR_Y_READY;
    end

    always_comb begin
        if (fir_adr_i == dma_fir_pkg::REG_CTRL)
            fir_rdat_o = status;
        else if (tap_hit)
            fir_rdat_o = taps[tap_idx];
        else if (fir_adr_i == dma_fir_pkg::REG_Y_OUT)
            fir_rdat_o = acc;  // holds the finished sum in y_ready
        else
            fir_rdat_o = '0;
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state   <= dma_fir_pkg::FIR_IDLE;
            mac_cnt <= '0;
            y_cnt   <= '0;
            done    <= 1'b0;
        end else if (start_wr) begin
            state   <= dma_fir_pkg::FIR_WAIT_X;
            mac_cnt <= '0;
            y_cnt   <= '0;
            done    <= 1'b0;
        end else begin
            case (state)
                dma_fir_pkg::FIR_WAIT_X: begin
                    if (x_wr) begin
                        mac_cnt <= '0;
                        state   <= dma_fir_pkg::FIR_MAC;
                    end
                end
                dma_fir_pkg::FIR_MAC: begin
                    mac_cnt <= mac_cnt + 1'b1;
                    if (mac_last)
                        state <= dma_fir_pkg::FIR_Y_READY;
                end
                dma_fir_pkg::FIR_Y_READY: begin
                    if (y_rd) begin
                        y_cnt <= y_cnt + 1'b1;
                        if (y_cnt == dma_fir_pkg::COUNT_W'(dma_fir_pkg::SAMPLE_COUNT - 1)) begin
                            done  <= 1'b1;
                            state <= dma_fir_pkg::FIR_IDLE;
                        end else begin
                            state <= dma_fir_pkg::FIR_WAIT_X;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    // taps, delay line and accumulator
    always_ff @(posedge wb_clk_i) begin
        if (wr && tap_hit)
            taps[tap_idx] <= fir_wdat_i;

        if (start_wr) begin
            for (int i = 0; i < dma_fir_pkg::NUM_TAPS; i++)
                delay[i] <= '0;
        end else if (x_wr) begin
            delay[0] <= fir_wdat_i;
            for (int i = 1; i < dma_fir_pkg::NUM_TAPS; i++)
                delay[i] <= delay[i-1];
        end

        if (x_wr)
            acc <= '0;
        else if (state == dma_fir_pkg::FIR_MAC)
            acc <= acc + product[dma_fir_pkg::DATA_W-1:0];  // wraps mod 2^32
    end

endmodule

`default_nettype wire

/* sdram_prefetch.sv */
`timescale 1ns/1ns
`default_nettype none

module sdram_prefetch (
    input  wire                                    wb_clk_i,
    input  wire                                    wb_rst_i,
    input  wire                                    base_load_i,
    input  wire  [dma_fir_pkg::SDRAM_ADDR_W-1:0]   base_addr_i,
    input  wire                                    sample_take_i,
    output logic [dma_fir_pkg::DATA_W-1:0]         sample_o,
    output logic                                   sample_valid_o,
    output logic [dma_fir_pkg::SDRAM_ADDR_W-1:0]   sdram_addr_o,
    output logic                                   sdram_req_o,
    input  wire                                    sdram_busy_i,
    input  wire  [dma_fir_pkg::DATA_W-1:0]         sdram_rdata_i,
    input  wire                                    sdram_rvalid_i
);

    dma_fir_pkg::prefetch_state_e state;
    logic [dma_fir_pkg::COUNT_W-1:0] word_cnt;
    logic capture;

    assign capture = (state == dma_fir_pkg::PF_REQUEST) && sdram_rvalid_i;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state          <= dma_fir_pkg::PF_IDLE;
            sdram_req_o    <= 1'b0;
            sdram_addr_o   <= '0;
            word_cnt       <= '0;
            sample_valid_o <= 1'b0;
        end else begin
            if (sample_take_i)
                sample_valid_o <= 1'b0;

            case (state)
                dma_fir_pkg::PF_IDLE: begin
                    if (base_load_i) begin
                        sdram_addr_o <= base_addr_i;
                        sdram_req_o  <= 1'b1;
                        word_cnt     <= '0;
                        state        <= dma_fir_pkg::PF_REQUEST;
                    end
                end
                dma_fir_pkg::PF_REQUEST: begin
                    if (!sdram_busy_i)
                        sdram_req_o <= 1'b0;  // held while the controller is busy
                    if (sdram_rvalid_i) begin
                        sample_valid_o <= 1'b1;
                        sdram_addr_o   <= sdram_addr_o + 1'b1;
                        word_cnt       <= word_cnt + 1'b1;
                        if (word_cnt == dma_fir_pkg::COUNT_W'(dma_fir_pkg::SAMPLE_COUNT - 1))
                            state <= dma_fir_pkg::PF_FINISHED;
                        else
                            state <= dma_fir_pkg::PF_HOLD;
                    end
                end
                dma_fir_pkg::PF_HOLD: begin
                    // next word only once the buffer is drained
                    if (!sample_valid_o) begin
                        sdram_req_o <= 1'b1;
                        state       <= dma_fir_pkg::PF_REQUEST;
                    end
                end
                default: ;  // stays in finished until reset
            endcase
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (capture)
            sample_o <= sdram_rdata_i;
    end

endmodule

`default_nettype wire

/* dma_fir_pkg.sv */
`default_nettype none

package dma_fir_pkg;

    localparam int DATA_W       = 32;
    localparam int SDRAM_ADDR_W = 23;  // sdram word address
    localparam int REG_ADDR_W   = 8;   // low byte of the wb address
    localparam int NUM_TAPS     = 11;
    localparam int TAP_IDX_W    = 4;
    localparam int SAMPLE_COUNT = 64;
    localparam int COUNT_W      = 7;

    // register map
    localparam logic [REG_ADDR_W-1:0] REG_CTRL        = 8'h00;
    localparam logic [REG_ADDR_W-1:0] REG_TAP_BASE    = 8'h40;
    localparam logic [REG_ADDR_W-1:0] REG_X_IN        = 8'h80;
    localparam logic [REG_ADDR_W-1:0] REG_Y_OUT       = 8'h84;
    localparam logic [REG_ADDR_W-1:0] REG_BASE_ADDR   = 8'h88;
    localparam logic [REG_ADDR_W-1:0] REG_RESULT_BASE = 8'h8C;

    // bits of REG_CTRL
    localparam int CTRL_START_BIT   = 0;
    localparam int CTRL_DONE_BIT    = 1;
    localparam int CTRL_IDLE_BIT    = 2;
    localparam int CTRL_X_READY_BIT = 4;
    localparam int CTRL_Y_VALID_BIT = 5;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_BASE_LOADED,
        SEQ_POLL,
        SEQ_STREAM_IN,
        SEQ_STREAM_OUT,
        SEQ_DONE
    } seq_state_e;

    typedef enum logic [1:0] {PF_IDLE, PF_REQUEST, PF_HOLD, PF_FINISHED} prefetch_state_e;

    typedef enum logic [1:0] {FIR_IDLE, FIR_WAIT_X, FIR_MAC, FIR_Y_READY} fir_state_e;

    // NUM_TAPS words at 4-byte steps from base
    function automatic logic word_in_window(input logic [REG_ADDR_W-1:0] off,
                                            input logic [REG_ADDR_W-1:0] base);
        logic [REG_ADDR_W-1:0] rel;
        rel = off - base;
        return (rel < REG_ADDR_W'(4 * NUM_TAPS)) && (rel[1:0] == 2'b00);
    endfunction

    function automatic logic [TAP_IDX_W-1:0] word_index(input logic [REG_ADDR_W-1:0] off,
                                                        input logic [REG_ADDR_W-1:0] base);
        logic [REG_ADDR_W-1:0] rel;
        rel = off - base;
        return rel[TAP_IDX_W+1:2];
    endfunction

endpackage

`default_nettype wire
